// ==== hw/capture_pkg.sv ====
// Shared types and constants for the capture block

package capture_pkg;

   // ----------------------------------------
   // Scheduler states
   // ----------------------------------------
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,   // Waiting for start
      ST_FILL  = 2'd1,   // Samples going into the block buffer
      ST_DRAIN = 2'd2,   // Block going out to the MCB
      ST_DONE  = 2'd3    // Parked until the next start
   } sched_state_e;

   // ----------------------------------------
   // Register map
   // ----------------------------------------
   typedef enum logic [1:0] {
      REG_CTRL  = 2'd0,  // Debug, const mode, delay
      REG_CDATA = 2'd1,  // Constant fake word
      REG_BASE  = 2'd2,  // Memory base address
      REG_START = 2'd3   // Write-only start command
   } reg_addr_e;

   // Bit positions inside REG_CTRL
   localparam int CTRL_DEBUG_BIT = 0;
   localparam int CTRL_CONST_BIT = 1;
   localparam int CTRL_DELAY_LSB = 2;   // Three bits wide

   // Fake source
   localparam int          LFSR_W    = 24;
   localparam logic [23:0] LFSR_SEED = 24'h5A5A5A;

   // MCB data bus width
   localparam int MCB_DW = 32;

endpackage

// ==== hw/capture_regs.sv ====
`timescale 1ns/10ps

// Configuration registers, written by a single-cycle strobe
module capture_regs #(
   parameter int AXNUM = 24,
   parameter int ABITS = 20
) (
   input  logic                     clk_e,
   input  logic                     rst_i,

   // Register write strobe
   input  logic                     reg_we_i,
   input  capture_pkg::reg_addr_e   reg_adr_i,
   input  logic [AXNUM-1:0]         reg_dat_i,

   // Configuration levels
   output logic                     debug_o,
   output logic                     const_mode_o,
   output logic [2:0]               delay_o,
   output logic [AXNUM-1:0]         cdata_o,
   output logic [ABITS-1:0]         base_o,

   // Start command
   output logic                     start_o
);

   // ----------------------------------------
   // Level registers
   // ----------------------------------------
   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         debug_o      <= 1'b0;
         const_mode_o <= 1'b0;
         delay_o      <= 3'd0;
         cdata_o      <= '0;
         base_o       <= '0;
      end else if (reg_we_i) begin
         case (reg_adr_i)
            capture_pkg::REG_CTRL: begin
               debug_o      <= reg_dat_i[capture_pkg::CTRL_DEBUG_BIT];
               const_mode_o <= reg_dat_i[capture_pkg::CTRL_CONST_BIT];
               delay_o      <= reg_dat_i[capture_pkg::CTRL_DELAY_LSB +: 3];
            end
            capture_pkg::REG_CDATA: begin
               cdata_o <= reg_dat_i;
            end
            capture_pkg::REG_BASE: begin
               base_o <= ABITS'(reg_dat_i);   // Truncate or zero-fill to address width
            end
            default: begin
               // REG_START leaves the levels alone
            end
         endcase
      end
   end

   // ----------------------------------------
   // Start pulse
   // ----------------------------------------
   // One cycle high, the cycle after the write
   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         start_o <= 1'b0;
      end else begin
         start_o <= reg_we_i && (reg_adr_i == capture_pkg::REG_START);
      end
   end

endmodule

// ==== hw/fake_antenna.sv ====
`timescale 1ns/10ps

// Debug data source, pseudo-random or constant
module fake_antenna #(
   parameter int AXNUM = 24
) (
   input  logic              clk_e,
   input  logic              rst_i,
   input  logic              start_i,      // Reload for a new block
   input  logic              fill_i,       // High while the buffer fills
   input  logic              const_mode_i,
   input  logic [AXNUM-1:0]  cdata_i,
   output logic [AXNUM-1:0]  fake_o
);

   logic [capture_pkg::LFSR_W-1:0] lfsr_q;
   logic [capture_pkg::LFSR_W-1:0] lfsr_src;
   logic [capture_pkg::LFSR_W-1:0] lfsr_nxt;
   logic                           fb;

   // ----------------------------------------
   // x^24 + x^23 + x^22 + x^17 + 1
   // ----------------------------------------
   // Stepping from the seed on start, otherwise from the current state
   assign lfsr_src = fill_i ? lfsr_q : capture_pkg::LFSR_SEED;
   assign fb       = lfsr_src[23] ^ lfsr_src[22] ^ lfsr_src[21] ^ lfsr_src[16];
   assign lfsr_nxt = {lfsr_src[22:0], fb};   // Shift left, feedback into bit 0

   // Output leads the fill state by one cycle, because the sample
   // register downstream eats a cycle; word 0 is the seed itself
   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         lfsr_q <= capture_pkg::LFSR_SEED;
      end else if (fill_i || start_i) begin
         lfsr_q <= lfsr_nxt;                  // Start reloads, fill advances
      end else begin
         lfsr_q <= capture_pkg::LFSR_SEED;    // Parked on the seed between blocks
      end
   end

   // ----------------------------------------
   // Output select
   // ----------------------------------------
   always_comb begin
      if (const_mode_i) begin
         fake_o = cdata_i;
      end else begin
         fake_o = AXNUM'(lfsr_q);   // 24-bit sequence
      end
   end

endmodule

// ==== hw/sample_delay.sv ====
`timescale 1ns/10ps

// Antenna capture with whole-cycle delay and fake/real select
module sample_delay #(
   parameter int AXNUM = 24
) (
   input  logic              clk_e,
   input  logic              rst_i,
   input  logic [AXNUM-1:0]  ax_data_i,   // Antenna word, one per clock
   input  logic [AXNUM-1:0]  fake_i,      // From the debug generator
   input  logic              debug_i,
   input  logic [2:0]        delay_i,     // 0..7 clocks
   output logic [AXNUM-1:0]  sample_o
);

   // ----------------------------------------
   // Tap line
   // ----------------------------------------
   // Seven stages behind the live input
   logic [7:1][AXNUM-1:0] tap_q;
   logic [7:0][AXNUM-1:0] taps;
   logic [AXNUM-1:0]      real_w;
   logic [AXNUM-1:0]      sel_w;

   always_ff @(posedge clk_e) begin
      tap_q <= {tap_q[6:1], ax_data_i};   // Oldest drops off the top
   end

   // Tap 0 is the live input, tap n is n clocks old
   assign taps = {tap_q, ax_data_i};

   always_comb begin
      real_w = taps[delay_i];
   end

   // ----------------------------------------
   // Source select and sample register
   // ----------------------------------------
   always_comb begin
      if (debug_i) begin
         sel_w = fake_i;      // Debug generator
      end else begin
         sel_w = real_w;      // Delayed antenna data
      end
   end

   // Same word feeds the buffer and the monitor port
   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         sample_o <= '0;
      end else begin
         sample_o <= sel_w;
      end
   end

endmodule

// ==== hw/block_buffer.sv ====
`timescale 1ns/10ps

// Simple dual-port block RAM for one capture block
module block_buffer #(
   parameter int AXNUM     = 24,
   parameter int BLOCK_LEN = 64
) (
   input  logic                          clk_e,

   // Write port, fill side
   input  logic                          wr_en_i,
   input  logic [$clog2(BLOCK_LEN)-1:0]  wr_adr_i,
   input  logic [AXNUM-1:0]              wr_dat_i,

   // Read port, drain side
   input  logic [$clog2(BLOCK_LEN)-1:0]  rd_adr_i,
   output logic [AXNUM-1:0]              rd_dat_o
);

   logic [AXNUM-1:0] mem [0:BLOCK_LEN-1];

   // ----------------------------------------
   // Write
   // ----------------------------------------
   always_ff @(posedge clk_e) begin
      if (wr_en_i) begin
         mem[wr_adr_i] <= wr_dat_i;
      end
   end

   // Registered read, data one clock after address
   always_ff @(posedge clk_e) begin
      rd_dat_o <= mem[rd_adr_i];
   end

endmodule

// ==== hw/store_scheduler.sv ====
`timescale 1ns/10ps

// Fill the block buffer after start, then drain it to the MCB
module store_scheduler #(
   parameter int AXNUM     = 24,
   parameter int ABITS     = 20,
   parameter int BLOCK_LEN = 64
) (
   input  logic                            clk_e,
   input  logic                            rst_i,
   input  logic                            start_i,
   input  logic [ABITS-1:0]                base_i,
   input  logic [AXNUM-1:0]                sample_i,
   input  logic [AXNUM-1:0]                buf_rd_dat_i,
   input  logic                            mcb_rdy_i,

   // Block buffer
   output logic                            buf_wr_en_o,
   output logic [$clog2(BLOCK_LEN)-1:0]    buf_wr_adr_o,
   output logic [AXNUM-1:0]                buf_wr_dat_o,
   output logic [$clog2(BLOCK_LEN)-1:0]    buf_rd_adr_o,

   // Fake generator
   output logic                            fill_o,

   // MCB command port
   output logic                            mcb_ce_o,
   output logic                            mcb_wr_o,
   output logic [ABITS-1:0]                mcb_adr_o,
   output logic [capture_pkg::MCB_DW-1:0]  mcb_dat_o,

   output capture_pkg::sched_state_e       state_o
);

   localparam int            AW       = $clog2(BLOCK_LEN);
   localparam int            CW       = AW + 1;
   localparam logic [AW-1:0] LAST_ADR = AW'(BLOCK_LEN - 1);
   localparam logic [CW-1:0] BLK_CNT  = CW'(BLOCK_LEN);

   logic [AW-1:0]                  fill_cnt;    // Next buffer write address
   logic [CW-1:0]                  issue_cnt;   // Words loaded into the command register
   logic [CW-1:0]                  issue_nxt;
   logic [AW-1:0]                  ack_cnt;     // Words taken by the MCB
   logic [ABITS-1:0]               base_q;
   logic                           rd_valid;    // Buffer output tracks issue_cnt
   logic                           start_ok;
   logic                           cmd_free;
   logic                           cmd_load;
   logic                           cmd_done;
   logic [capture_pkg::MCB_DW-1:0] rd_word;

   // ----------------------------------------
   // Handshake decode
   // ----------------------------------------
   assign start_ok = start_i && (state_o == capture_pkg::ST_IDLE ||
                                 state_o == capture_pkg::ST_DONE);
   assign cmd_done = mcb_ce_o && mcb_rdy_i;       // Transfer completes this edge
   assign cmd_free = !mcb_ce_o || mcb_rdy_i;      // Command register can take a word
   assign cmd_load = (state_o == capture_pkg::ST_DRAIN) && rd_valid &&
                     (issue_cnt != BLK_CNT) && cmd_free;

   // Read address runs one word ahead, so the RAM output is always
   // the word the command register takes next
   assign issue_nxt    = cmd_load ? issue_cnt + CW'(1) : issue_cnt;
   assign buf_rd_adr_o = issue_nxt[AW-1:0];

   // Fill side
   assign fill_o       = (state_o == capture_pkg::ST_FILL);
   assign buf_wr_en_o  = fill_o;
   assign buf_wr_adr_o = fill_cnt;
   assign buf_wr_dat_o = sample_i;   // Sample k lands at address k

   always_comb begin
      rd_word                = '0;             // Zero-extend to the MCB width
      rd_word[AXNUM-1:0]     = buf_rd_dat_i;
   end

   // ----------------------------------------
   // State machine
   // ----------------------------------------
   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         state_o   <= capture_pkg::ST_IDLE;
         fill_cnt  <= '0;
         issue_cnt <= '0;
         ack_cnt   <= '0;
         rd_valid  <= 1'b0;
      end else begin
         rd_valid <= (state_o == capture_pkg::ST_DRAIN);   // First drain cycle primes the RAM
         case (state_o)
            capture_pkg::ST_IDLE, capture_pkg::ST_DONE: begin
               if (start_ok) begin
                  state_o   <= capture_pkg::ST_FILL;
                  fill_cnt  <= '0;
                  issue_cnt <= '0;
                  ack_cnt   <= '0;
               end
            end
            capture_pkg::ST_FILL: begin
               fill_cnt <= fill_cnt + AW'(1);
               if (fill_cnt == LAST_ADR) begin
                  state_o <= capture_pkg::ST_DRAIN;
               end
            end
            capture_pkg::ST_DRAIN: begin
               issue_cnt <= issue_nxt;
               if (cmd_done) begin
                  ack_cnt <= ack_cnt + AW'(1);
                  if (ack_cnt == LAST_ADR) begin
                     state_o <= capture_pkg::ST_DONE;   // Last word accepted
                  end
               end
            end
            default: begin
               state_o <= capture_pkg::ST_IDLE;
            end
         endcase
      end
   end

   // Base held for the whole block
   always_ff @(posedge clk_e) begin
      if (start_ok) begin
         base_q <= base_i;
      end
   end

   // ----------------------------------------
   // MCB command register
   // ----------------------------------------
   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         mcb_ce_o <= 1'b0;
      end else if (cmd_load) begin
         mcb_ce_o <= 1'b1;
      end else if (cmd_done) begin
         mcb_ce_o <= 1'b0;
      end
   end

   // Address and data only move when a new word is loaded
   always_ff @(posedge clk_e) begin
      if (cmd_load) begin
         mcb_adr_o <= base_q + ABITS'(issue_cnt);
         mcb_dat_o <= rd_word;
      end
   end

   assign mcb_wr_o = mcb_ce_o;   // Write-only master

endmodule

// ==== hw/capture_top.sv ====
`timescale 1ns/10ps

// Capture block top level
module capture_top #(
   parameter int AXNUM     = 24,
   parameter int ABITS     = 20,
   parameter int BLOCK_LEN = 64
) (
   input  logic                            clk_e,
   input  logic                            rst_i,

   // Register writes
   input  logic                            reg_we_i,
   input  capture_pkg::reg_addr_e          reg_adr_i,
   input  logic [AXNUM-1:0]                reg_dat_i,

   // Antenna data in, selected stream out
   input  logic [AXNUM-1:0]                ax_data_i,
   output logic [AXNUM-1:0]                ax_data_o,

   // Memory controller
   output logic                            mcb_ce_o,
   output logic                            mcb_wr_o,
   output logic [ABITS-1:0]                mcb_adr_o,
   output logic [capture_pkg::MCB_DW-1:0]  mcb_dat_o,
   input  logic                            mcb_rdy_i,

   output capture_pkg::sched_state_e       state_o
);

   // ----------------------------------------
   // Configuration and control
   // ----------------------------------------
   logic                          debug;
   logic                          const_mode;
   logic [2:0]                    delay;
   logic [AXNUM-1:0]              cdata;
   logic [ABITS-1:0]              base;
   logic                          start;
   logic                          fill;
   logic [AXNUM-1:0]              fake;

   // Buffer ports
   logic                          buf_wr_en;
   logic [$clog2(BLOCK_LEN)-1:0]  buf_wr_adr;
   logic [AXNUM-1:0]              buf_wr_dat;
   logic [$clog2(BLOCK_LEN)-1:0]  buf_rd_adr;
   logic [AXNUM-1:0]              buf_rd_dat;

   capture_regs #(.AXNUM(AXNUM), .ABITS(ABITS)) u_regs (
      .clk_e(clk_e), .rst_i(rst_i),
      .reg_we_i(reg_we_i), .reg_adr_i(reg_adr_i), .reg_dat_i(reg_dat_i),
      .debug_o(debug), .const_mode_o(const_mode), .delay_o(delay),
      .cdata_o(cdata), .base_o(base), .start_o(start)
   );

   fake_antenna #(.AXNUM(AXNUM)) u_fake (
      .clk_e(clk_e), .rst_i(rst_i), .start_i(start), .fill_i(fill),
      .const_mode_i(const_mode), .cdata_i(cdata), .fake_o(fake)
   );

   // Sample register also drives the monitor port
   sample_delay #(.AXNUM(AXNUM)) u_delay (
      .clk_e(clk_e), .rst_i(rst_i), .ax_data_i(ax_data_i), .fake_i(fake),
      .debug_i(debug), .delay_i(delay), .sample_o(ax_data_o)
   );

   block_buffer #(.AXNUM(AXNUM), .BLOCK_LEN(BLOCK_LEN)) u_buf (
      .clk_e(clk_e), .wr_en_i(buf_wr_en), .wr_adr_i(buf_wr_adr),
      .wr_dat_i(buf_wr_dat), .rd_adr_i(buf_rd_adr), .rd_dat_o(buf_rd_dat)
   );

   store_scheduler #(.AXNUM(AXNUM), .ABITS(ABITS), .BLOCK_LEN(BLOCK_LEN)) u_sched (
      .clk_e(clk_e), .rst_i(rst_i), .start_i(start), .base_i(base),
      .sample_i(ax_data_o), .buf_rd_dat_i(buf_rd_dat), .mcb_rdy_i(mcb_rdy_i),
      .buf_wr_en_o(buf_wr_en), .buf_wr_adr_o(buf_wr_adr),
      .buf_wr_dat_o(buf_wr_dat), .buf_rd_adr_o(buf_rd_adr), .fill_o(fill),
      .mcb_ce_o(mcb_ce_o), .mcb_wr_o(mcb_wr_o), .mcb_adr_o(mcb_adr_o),
      .mcb_dat_o(mcb_dat_o), .state_o(state_o)
   );

endmodule

// ==== bench/capture_clock.sv ====
`timescale 1ns/10ps

// Testbench clock and power-on reset
module capture_clock #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 4
) (
   output logic clk_e,
   output logic rst_o
);

   initial begin
      clk_e = 1'b0;
      forever #(PERIOD_NS / 2) clk_e = ~clk_e;   // 50 % duty
   end

   // Reset high for the first few edges, released just after an edge
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_e);
      #2;
      rst_o = 1'b0;
   end

endmodule

// ==== bench/capture_tb.sv ====
`timescale 1ns/10ps

module capture_tb;

   localparam int AXNUM       = 24;
   localparam int ABITS       = 20;
   localparam int BLOCK_LEN   = 64;
   localparam int DW          = capture_pkg::MCB_DW;
   localparam int TIMEOUT_CYC = 8 * (BLOCK_LEN * 4 + 40);

   // Source of a block
   localparam int MODE_REAL  = 0;
   localparam int MODE_PRBS  = 1;
   localparam int MODE_CONST = 2;

   logic                       clk_e;
   logic                       rst_i;
   logic                       reg_we_i;
   capture_pkg::reg_addr_e     reg_adr_i;
   logic [AXNUM-1:0]           reg_dat_i;
   logic [AXNUM-1:0]           ax_data_i;
   logic [AXNUM-1:0]           ax_data_o;
   logic                       mcb_ce_o;
   logic                       mcb_wr_o;
   logic [ABITS-1:0]           mcb_adr_o;
   logic [DW-1:0]              mcb_dat_o;
   logic                       mcb_rdy_i;
   capture_pkg::sched_state_e  state_o;

   int               seed;
   int               edge_no;        // Rising edges seen so far
   int               error_cnt;
   int               check_cnt;
   int               last_wr_edge;   // Edge that sampled the last register strobe
   int               stretch;        // Cycles left in a forced ready-low run
   logic [31:0]      rnd;
   logic [AXNUM-1:0] ax_log [int];   // Antenna word present at each edge
   logic [DW-1:0]    mem_model [int];
   int               wr_count [int];

   // Current block
   int               blk_num;
   int               blk_start;      // Edge where the scheduler saw start
   int               blk_delay;
   int               blk_mode;
   int               blk_base;
   int               blk_writes;
   logic [AXNUM-1:0] blk_const;
   logic             started_any;
   logic             hold_valid;     // Command pending without ready last edge
   logic [ABITS-1:0] hold_adr;
   logic [DW-1:0]    hold_dat;
   event             block_done;

   capture_clock #(.PERIOD_NS(40), .RST_CYCLES(4)) u_clk (.clk_e(clk_e), .rst_o(rst_i));

   capture_top #(.AXNUM(AXNUM), .ABITS(ABITS), .BLOCK_LEN(BLOCK_LEN)) UUT (
      .clk_e(clk_e), .rst_i(rst_i),
      .reg_we_i(reg_we_i), .reg_adr_i(reg_adr_i), .reg_dat_i(reg_dat_i),
      .ax_data_i(ax_data_i), .ax_data_o(ax_data_o),
      .mcb_ce_o(mcb_ce_o), .mcb_wr_o(mcb_wr_o), .mcb_adr_o(mcb_adr_o),
      .mcb_dat_o(mcb_dat_o), .mcb_rdy_i(mcb_rdy_i), .state_o(state_o)
   );

   // ----------------------------------------
   // Reference model
   // ----------------------------------------
   // x^24+x^23+x^22+x^17+1, shift left, feedback into bit 0
   function automatic logic [23:0] lfsr_step(input logic [23:0] s);
      return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
   endfunction

   function automatic logic [AXNUM-1:0] expected_sample(input int k, input int mode);
      logic [23:0] s;
      int          i;
      s = capture_pkg::LFSR_SEED;
      if (mode == MODE_CONST) begin
         return blk_const;
      end
      if (mode == MODE_REAL) begin
         return ax_log[blk_start + k - blk_delay];   // Word seen k edges after start, less delay
      end
      for (i = 0; i < k; i++) begin
         s = lfsr_step(s);
      end
      return AXNUM'(s);
   endfunction

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------
   task automatic check_word(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] act);
      check_cnt++;
      if (act !== exp) begin
         error_cnt++;
         $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
      end
   endtask

   task automatic check_sample(input string name, input logic [AXNUM-1:0] exp,
                               input logic [AXNUM-1:0] act);
      check_cnt++;
      if (act !== exp) begin
         error_cnt++;
         $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input logic [ABITS-1:0] exp,
                             input logic [ABITS-1:0] act);
      check_cnt++;
      if (act !== exp) begin
         error_cnt++;
         $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
      end
   endtask

   task automatic check_state(input string name, input capture_pkg::sched_state_e exp,
                              input capture_pkg::sched_state_e act);
      check_cnt++;
      if (act !== exp) begin
         error_cnt++;
         $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      check_cnt++;
      if (act !== exp) begin
         error_cnt++;
         $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
      end
   endtask

   task automatic report_and_finish();
      $display("Run ended at edge %0d: %0d checks, %0d errors", edge_no, check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   // ----------------------------------------
   // Edge monitor, memory responder model
   // ----------------------------------------
   always @(posedge clk_e) begin
      edge_no = edge_no + 1;
      if (!rst_i) begin
         if (!started_any) begin
            check_state("state_o", capture_pkg::ST_IDLE, state_o);
            check_flag("mcb_ce_o", 1'b0, mcb_ce_o);
            check_flag("mcb_wr_o", 1'b0, mcb_wr_o);
         end else if (edge_no > blk_start && edge_no <= blk_start + BLOCK_LEN) begin
            // Fill window, monitor port carries sample k
            check_state("state_o", capture_pkg::ST_FILL, state_o);
            check_sample("ax_data_o", expected_sample(edge_no - blk_start - 1, blk_mode),
                         ax_data_o);
         end else if (edge_no == blk_start + BLOCK_LEN + 1) begin
            check_state("state_o", capture_pkg::ST_DRAIN, state_o);   // Fill is one block long
         end
         if (hold_valid) begin                     // Stalled command must not move
            check_flag("mcb_ce_o", 1'b1, mcb_ce_o);
            check_addr("mcb_adr_o", hold_adr, mcb_adr_o);
            check_word("mcb_dat_o", hold_dat, mcb_dat_o);
         end
         if (mcb_ce_o && mcb_rdy_i) begin          // Transfer completes here
            check_flag("mcb_wr_o", 1'b1, mcb_wr_o);
            mem_model[int'(mcb_adr_o)] = mcb_dat_o;
            if (wr_count.exists(int'(mcb_adr_o))) begin
               wr_count[int'(mcb_adr_o)] = wr_count[int'(mcb_adr_o)] + 1;
            end else begin
               wr_count[int'(mcb_adr_o)] = 1;
            end
            blk_writes++;
         end
         hold_valid = mcb_ce_o && !mcb_rdy_i;
         hold_adr   = mcb_adr_o;
         hold_dat   = mcb_dat_o;
      end
      if (edge_no >= TIMEOUT_CYC) begin
         error_cnt++;
         $display("ERROR: timeout, run still busy after %0d cycles", TIMEOUT_CYC);
         report_and_finish();
      end
   end

   // Antenna words and ready, driven just after each edge
   always @(posedge clk_e) begin
      #2;
      rnd = $random(seed);
      ax_data_i = rnd[AXNUM-1:0];
      ax_log[edge_no + 1] = rnd[AXNUM-1:0];    // Sampled at the next edge
      rnd = $random(seed);
      if (stretch > 0) begin
         mcb_rdy_i = 1'b0;
         stretch--;
      end else if (rnd[5:0] == 6'd0) begin
         mcb_rdy_i = 1'b0;                     // Start of a 20-cycle stall
         stretch   = 19;
      end else begin
         mcb_rdy_i = rnd[8] | rnd[9];          // Ready about 3 of 4 cycles
      end
   end

   // ----------------------------------------
   // Block compare
   // ----------------------------------------
   task automatic compare_block();
      int            a;
      int            k;
      logic [DW-1:0] exp_w;
      if (blk_writes != BLOCK_LEN) begin
         error_cnt++;
         $display("ERROR: block %0d wrote %0d words, expected %0d", blk_num, blk_writes, BLOCK_LEN);
      end
      for (k = 0; k < BLOCK_LEN; k++) begin
         a     = blk_base + k;
         exp_w = DW'(expected_sample(k, blk_mode));   // Zero-extended sample
         if (!mem_model.exists(a)) begin
            error_cnt++;
            $display("ERROR: block %0d never wrote word %0d at address 0x%h", blk_num, k, a);
         end else begin
            if (wr_count[a] != 1) begin
               error_cnt++;
               $display("ERROR: block %0d wrote address 0x%h %0d times", blk_num, a, wr_count[a]);
            end
            check_word($sformatf("mcb_dat_o at 0x%h", a), exp_w, mem_model[a]);
         end
      end
      if (mem_model.num() != BLOCK_LEN) begin
         error_cnt++;
         $display("ERROR: block %0d wrote outside its address range", blk_num);
      end
   endtask

   always @(block_done) begin
      compare_block();
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   task automatic write_reg(input capture_pkg::reg_addr_e adr, input logic [AXNUM-1:0] dat);
      @(posedge clk_e);
      #2;
      reg_we_i     = 1'b1;
      reg_adr_i    = adr;
      reg_dat_i    = dat;
      last_wr_edge = edge_no + 1;
      @(posedge clk_e);
      #2;
      reg_we_i = 1'b0;
   endtask

   task automatic run_block(input int mode, input logic [2:0] d, input int base,
                            input logic [AXNUM-1:0] cdata, input logic dup_start);
      logic [AXNUM-1:0] ctrl;
      ctrl = '0;
      ctrl[capture_pkg::CTRL_DEBUG_BIT]     = (mode != MODE_REAL);
      ctrl[capture_pkg::CTRL_CONST_BIT]     = (mode == MODE_CONST);
      ctrl[capture_pkg::CTRL_DELAY_LSB +: 3] = d;
      write_reg(capture_pkg::REG_CTRL, ctrl);
      write_reg(capture_pkg::REG_CDATA, cdata);
      write_reg(capture_pkg::REG_BASE, AXNUM'(base));
      mem_model.delete();
      wr_count.delete();
      blk_writes = 0;
      blk_num++;
      blk_mode  = mode;
      blk_delay = int'(d);
      blk_base  = base;
      blk_const = cdata;
      write_reg(capture_pkg::REG_START, '0);
      blk_start   = last_wr_edge + 1;   // Start pulse one edge after the strobe
      started_any = 1'b1;
      if (dup_start) begin
         repeat (4) @(posedge clk_e);
         write_reg(capture_pkg::REG_START, '0);   // Lands mid-fill
      end
      while (state_o != capture_pkg::ST_FILL) begin
         @(posedge clk_e);
         #2;
      end
      while (state_o != capture_pkg::ST_DONE) begin
         @(posedge clk_e);
         #2;
      end
      @(posedge clk_e);
      #2;
      check_state("state_o", capture_pkg::ST_DONE, state_o);   // Parked until the next start
      -> block_done;
   endtask

   initial begin
      seed        = 32'h7591;
      edge_no     = 0;
      error_cnt   = 0;
      check_cnt   = 0;
      stretch     = 0;
      blk_num     = 0;
      blk_writes  = 0;
      started_any = 1'b0;
      hold_valid  = 1'b0;
      reg_we_i    = 1'b0;
      reg_adr_i   = capture_pkg::REG_CTRL;
      reg_dat_i   = '0;
      ax_data_i   = '0;
      mcb_rdy_i   = 1'b0;
      ax_log[1]   = '0;
      wait (rst_i === 1'b0);
      repeat (3) @(posedge clk_e);                  // Idle after reset

      run_block(MODE_REAL, 3'd0, 'h000, '0, 1'b0);
      run_block(MODE_REAL, 3'd5, 'h100, '0, 1'b0);
      run_block(MODE_PRBS, 3'd0, 'h200, '0, 1'b0);
      run_block(MODE_PRBS, 3'd0, 'h200, '0, 1'b0);   // Same sequence again
      run_block(MODE_CONST, 3'd0, 'h300, 24'hC0FFEE, 1'b1);
      @(posedge clk_e);
      report_and_finish();
   end

endmodule

// ==== src.f ====
hw/capture_pkg.sv
hw/capture_regs.sv
hw/fake_antenna.sv
hw/sample_delay.sv
hw/block_buffer.sv
hw/store_scheduler.sv
hw/capture_top.sv
bench/capture_clock.sv
bench/capture_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the capture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module capture_tb -f src.f -o capture_sim

./obj_dir/capture_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
   echo "Simulation reported errors, see sim.log"
   exit 1
fi

if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi

echo "Simulation clean"
